// ==== apb_regblk.f ====
regblk_pkg.sv
apb_slave_port.sv
reg_slice.sv
read_data_mux.sv
apb_regblk.sv
tb_apb_regblk.sv

// ==== apb_regblk.sv ====
`default_nettype none

module apb_regblk import regblk_pkg::*; #(
  parameter int    NUM_REGS     = regblk_pkg::NUM_REGS,
  parameter addr_t BASE_ADDRESS = regblk_pkg::BASE_ADDRESS
) (
  input  wire logic                 clk,
  input  wire logic                 i_rst_n,
  input  wire logic                 i_psel,
  input  wire logic                 i_penable,
  input  wire logic                 i_pwrite,
  input  wire addr_t                i_paddr,
  input  wire data_t                i_pwdata,
  input  wire strb_t                i_pstrb,
  input  wire data_t [NUM_REGS-1:0] i_hw_in,
  output logic                      o_pready,
  output logic                      o_pslverr,
  output data_t                     o_prdata,
  output data_t [NUM_REGS-1:0]      o_hw_out
);

  logic  [NUM_REGS-1:0] sel;
  logic                 wr_stb;
  logic                 rd_stb;
  logic                 err;
  data_t                wdata;
  strb_t                wstrb;
  data_t [NUM_REGS-1:0] rd_value;

  apb_slave_port #(
    .NUM_REGS     (NUM_REGS),
    .BASE_ADDRESS (BASE_ADDRESS)
  ) u_port (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .i_pstrb   (i_pstrb),
    .o_pready  (o_pready),
    .o_sel     (sel),
    .o_wr_stb  (wr_stb),
    .o_rd_stb  (rd_stb),
    .o_err     (err),
    .o_wdata   (wdata),
    .o_wstrb   (wstrb)
  );

  // **********************************************************************
  // register array
  // **********************************************************************

  for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
    reg_slice #(
      .KIND        (REG_KINDS[i]),
      .RESET_VALUE (RESET_VALUES[i])
    ) u_slice (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_sel      (sel[i]),
      .i_wr_stb   (wr_stb),
      .i_wdata    (wdata),
      .i_wstrb    (wstrb),
      .i_hw_in    (i_hw_in[i]),
      .o_rd_value (rd_value[i]),
      .o_hw_out   (o_hw_out[i])
    );
  end

  read_data_mux #(
    .NUM_REGS (NUM_REGS)
  ) u_mux (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_sel      (sel),
    .i_rd_stb   (rd_stb),
    .i_wr_stb   (wr_stb),
    .i_err      (err),
    .i_rd_value (rd_value),
    .o_prdata   (o_prdata),
    .o_pslverr  (o_pslverr)
  );

endmodule

`default_nettype wire

// ==== apb_slave_port.sv ====
`default_nettype none

module apb_slave_port import regblk_pkg::*; #(
  parameter int    NUM_REGS     = regblk_pkg::NUM_REGS,
  parameter addr_t BASE_ADDRESS = regblk_pkg::BASE_ADDRESS
) (
  input  wire logic                clk,
  input  wire logic                i_rst_n,
  input  wire logic                i_psel,
  input  wire logic                i_penable,
  input  wire logic                i_pwrite,
  input  wire addr_t               i_paddr,
  input  wire data_t               i_pwdata,
  input  wire strb_t               i_pstrb,
  output logic                     o_pready,
  output logic [NUM_REGS-1:0]      o_sel,
  output logic                     o_wr_stb,
  output logic                     o_rd_stb,
  output logic                     o_err,
  output data_t                    o_wdata,
  output strb_t                    o_wstrb
);

  localparam addr_t MAP_SIZE = addr_t'(NUM_REGS * 4);

  apb_state_e state_q;
  apb_state_e state_d;
  addr_t      offset;
  logic       in_range;
  logic       aligned;
  logic       addr_ok;
  logic       access;

  // **********************************************************************
  // address decode
  // **********************************************************************

  assign offset   = i_paddr - BASE_ADDRESS;
  assign in_range = (i_paddr >= BASE_ADDRESS) && (offset < MAP_SIZE);
  assign aligned  = (i_paddr[1:0] == 2'b00);
  assign addr_ok  = in_range && aligned;

  always_comb begin
    o_sel = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (addr_ok && (offset == addr_t'(i * 4))) begin
        o_sel[i] = 1'b1;
      end
    end
  end

  assign o_err = !addr_ok;  // empty select on error

  // **********************************************************************
  // handshake FSM
  // **********************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_psel && !i_penable) begin  // setup phase seen
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        state_d = ST_READY;
      end
      ST_READY: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign access   = (state_q == ST_WAIT) && i_psel && i_penable;
  assign o_wr_stb = access && i_pwrite;
  assign o_rd_stb = access && !i_pwrite;
  assign o_pready = (state_q == ST_READY);

  // master holds these through the access phase
  assign o_wdata = i_pwdata;
  assign o_wstrb = i_pwrite ? i_pstrb : '0;

endmodule

`default_nettype wire

// ==== read_data_mux.sv ====
`default_nettype none

module read_data_mux import regblk_pkg::*; #(
  parameter int NUM_REGS = regblk_pkg::NUM_REGS
) (
  input  wire logic                   clk,
  input  wire logic                   i_rst_n,
  input  wire logic  [NUM_REGS-1:0]   i_sel,
  input  wire logic                   i_rd_stb,
  input  wire logic                   i_wr_stb,
  input  wire logic                   i_err,
  input  wire data_t [NUM_REGS-1:0]   i_rd_value,
  output data_t                       o_prdata,
  output logic                        o_pslverr
);

  data_t sel_value;
  data_t prdata_q;
  logic  pslverr_q;

  // one-hot select, so an OR of masked values is enough
  always_comb begin
    sel_value = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (i_sel[i]) begin
        sel_value = sel_value | i_rd_value[i];
      end
    end
  end

  // **********************************************************************
  // response registers
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      prdata_q  <= '0;
      pslverr_q <= 1'b0;
    end else begin
      if ((i_rd_stb || i_wr_stb) && i_err) begin
        prdata_q <= DEFAULT_READ_DATA;
      end else if (i_rd_stb) begin
        prdata_q <= sel_value;
      end
      if (i_rd_stb || i_wr_stb) begin
        pslverr_q <= i_err;  // lines up with pready
      end
    end
  end

  assign o_prdata  = prdata_q;
  assign o_pslverr = pslverr_q;

endmodule

`default_nettype wire

// ==== reg_slice.sv ====
`default_nettype none

module reg_slice import regblk_pkg::*; #(
  parameter reg_kind_e KIND        = KIND_RW,
  parameter data_t     RESET_VALUE = '0
) (
  input  wire logic  clk,
  input  wire logic  i_rst_n,
  input  wire logic  i_sel,
  input  wire logic  i_wr_stb,
  input  wire data_t i_wdata,
  input  wire strb_t i_wstrb,
  input  wire data_t i_hw_in,
  output data_t      o_rd_value,
  output data_t      o_hw_out
);

  data_t value_q;
  data_t value_d;
  data_t wr_mask;
  data_t wr_bits;
  logic  wr_en;

  // **********************************************************************
  // write qualification
  // **********************************************************************

  assign wr_en = i_sel && i_wr_stb;

  always_comb begin
    wr_mask = '0;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      wr_mask[b*8 +: 8] = {8{i_wstrb[b]}};
    end
  end

  assign wr_bits = wr_en ? (i_wdata & wr_mask) : '0;  // strobed write bits

  // **********************************************************************
  // next value by kind
  // **********************************************************************

  always_comb begin
    value_d = value_q;
    case (KIND)
      KIND_RW: begin
        if (wr_en) begin
          value_d = (value_q & ~wr_mask) | wr_bits;
        end
      end
      KIND_RO: begin
        value_d = i_hw_in;  // sampled every cycle
      end
      KIND_W1C: begin
        value_d = (value_q & ~wr_bits) | i_hw_in;  // set wins over clear
      end
      KIND_TRIG: begin
        value_d = wr_bits;  // self-clearing
      end
      default: begin
        value_d = value_q;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      value_q <= RESET_VALUE;
    end else begin
      value_q <= value_d;
    end
  end

  // **********************************************************************
  // bus and hardware views
  // **********************************************************************

  always_comb begin
    case (KIND)
      KIND_RW: begin
        o_rd_value = value_q;
        o_hw_out   = value_q;
      end
      KIND_RO: begin
        o_rd_value = value_q;
        o_hw_out   = '0;      // nothing driven back
      end
      KIND_W1C: begin
        o_rd_value = value_q;
        o_hw_out   = value_q; // sticky status
      end
      KIND_TRIG: begin
        o_rd_value = '0;
        o_hw_out   = value_q; // pulse
      end
      default: begin
        o_rd_value = '0;
        o_hw_out   = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== regblk_input.txt ====
// columns: op addr data strb exp_data exp_err, all hex
// op: 0 write, 1 read, 2 drive hw_in[addr], 3 trigger write, 4 check hw_out[addr], F end
1 1000 00000000 0 000000A5 0
1 1004 00000000 0 00000000 0
1 1008 00000000 0 00000000 0
1 100C 00000000 0 00000000 0
4 0000 00000000 0 000000A5 0
4 0003 00000000 0 00000000 0
// rw register, partial byte strobes
0 1000 11223344 5 00000000 0
1 1000 00000000 0 00220044 0
4 0000 00000000 0 00220044 0
0 1000 AABBCCDD 8 00000000 0
1 1000 00000000 0 AA220044 0
4 0000 00000000 0 AA220044 0
// ro register follows hw_in, ignores writes
2 0001 5A5A1234 0 00000000 0
1 1004 00000000 0 5A5A1234 0
0 1004 FFFFFFFF F 00000000 0
1 1004 00000000 0 5A5A1234 0
// w1c register, one-cycle set pulse then clear two bits
2 0002 000000F0 0 00000000 0
2 0002 00000000 0 00000000 0
1 1008 00000000 0 000000F0 0
0 1008 00000030 F 00000000 0
1 1008 00000000 0 000000C0 0
// trigger register, low two bytes strobed
3 100C 87654321 3 00004321 0
1 100C 00000000 0 00000000 0
// unmapped and misaligned accesses
0 1010 12345678 F 00000000 1
1 1010 00000000 0 DEADBEAF 1
1 1002 00000000 0 DEADBEAF 1
0 1002 FFFFFFFF F 00000000 1
1 1000 00000000 0 AA220044 0
1 1004 00000000 0 5A5A1234 0
1 1008 00000000 0 000000C0 0
4 0000 00000000 0 AA220044 0
F 0000 00000000 0 00000000 0

// ==== regblk_pkg.sv ====
`default_nettype none

package regblk_pkg;

  // **********************************************************************
  // bus widths
  // **********************************************************************

  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // **********************************************************************
  // address map
  // **********************************************************************

  localparam int    NUM_REGS          = 4;
  localparam addr_t BASE_ADDRESS      = 16'h1000;       // register 0, then +4 each
  localparam data_t DEFAULT_READ_DATA = 32'hDEADBEAF;   // returned with pslverr

  // **********************************************************************
  // register kinds
  // **********************************************************************

  typedef enum logic [1:0] {
    KIND_RW   = 2'd0,   // read/write, drives hardware
    KIND_RO   = 2'd1,   // samples hardware
    KIND_W1C  = 2'd2,   // sticky set, write one to clear
    KIND_TRIG = 2'd3    // one-cycle pulse on write
  } reg_kind_e;

  localparam reg_kind_e REG_KINDS [NUM_REGS] = '{
    KIND_RW,
    KIND_RO,
    KIND_W1C,
    KIND_TRIG
  };

  localparam data_t RESET_VALUES [NUM_REGS] = '{
    32'h0000_00A5,
    32'h0000_0000,
    32'h0000_0000,
    32'h0000_0000
  };

  // apb slave handshake
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,    // waiting for setup
    ST_WAIT  = 2'd1,    // first access cycle, strobes out
    ST_READY = 2'd2     // second access cycle, pready high
  } apb_state_e;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot change to the project directory"
  exit 1
fi

verilator --binary --timing -j 0 --top-module tb_apb_regblk -f apb_regblk.f -o tb_apb_regblk
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/tb_apb_regblk)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the testbench prints the pass line only when every check held
echo "$sim_output" | grep -q "^SIMULATION PASSED$"
if [ $? -ne 0 ]; then
  exit 1
fi
exit 0

// ==== tb_apb_regblk.sv ====
`default_nettype none

module tb_apb_regblk import regblk_pkg::*; ();

  localparam int MAX_OPS        = 64;
  localparam int WORDS_PER_OP   = 6;   // op addr data strb exp_data exp_err
  localparam int PREADY_TIMEOUT = 20;
  localparam int IDX_W          = $clog2(NUM_REGS);

  localparam logic [31:0] OP_WRITE    = 32'h0;
  localparam logic [31:0] OP_READ     = 32'h1;
  localparam logic [31:0] OP_HW_DRIVE = 32'h2;
  localparam logic [31:0] OP_TRIGGER  = 32'h3;
  localparam logic [31:0] OP_HW_CHECK = 32'h4;
  localparam logic [31:0] OP_END      = 32'hF;

  typedef logic [IDX_W-1:0] idx_t;

  logic                 clk;
  logic                 rst_n;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  addr_t                paddr;
  data_t                pwdata;
  strb_t                pstrb;
  data_t [NUM_REGS-1:0] hw_in;
  logic                 pready;
  logic                 pslverr;
  data_t                prdata;
  data_t [NUM_REGS-1:0] hw_out;

  logic [31:0] vec_mem [MAX_OPS*WORDS_PER_OP];
  int          pass_count;
  int          fail_count;
  logic        timeout_hit;

  apb_regblk #(
    .NUM_REGS     (NUM_REGS),
    .BASE_ADDRESS (BASE_ADDRESS)
  ) i_dut (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .i_pstrb   (pstrb),
    .i_hw_in   (hw_in),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .o_prdata  (prdata),
    .o_hw_out  (hw_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // **********************************************************************
  // compare tasks
  // **********************************************************************

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual === expected) begin
      $display("Pass %s: %h", name, actual);
      pass_count++;
    end else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      fail_count++;
    end
  endtask

  task automatic check_err(input string name, input logic expected, input logic actual);
    if (actual === expected) begin
      $display("Pass %s: %b", name, actual);
      pass_count++;
    end else begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      fail_count++;
    end
  endtask

  // **********************************************************************
  // apb master
  // **********************************************************************

  // one transfer, also samples hw_out[hw_idx] in both access cycles
  task automatic apb_transfer(input string name, input logic write, input addr_t addr,
                              input data_t data, input strb_t strb, input idx_t hw_idx,
                              output data_t rdata, output logic err,
                              output data_t hw_access, output data_t hw_ready,
                              output logic ok);
    int waited;
    @(posedge clk);
    #1;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(posedge clk);
    #1;
    hw_access = hw_out[hw_idx];
    penable   = 1'b1;
    waited    = 0;
    ok        = 1'b0;
    while (!ok && waited < PREADY_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
      if (pready) begin
        ok = 1'b1;
      end
    end
    hw_ready = hw_out[hw_idx];
    rdata    = prdata;
    err      = pslverr;
    if (ok) begin
      @(posedge clk);  // transfer completes at this edge
      #1;
    end else begin
      $display("%s: o_pready stayed low for %0d cycles", name, PREADY_TIMEOUT);
      fail_count++;
      timeout_hit = 1'b1;
    end
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pstrb    = '0;
  endtask

  // **********************************************************************
  // vector file operations
  // **********************************************************************

  task automatic run_op(input int n, output logic stop);
    int          base;
    logic [31:0] op;
    addr_t       addr;
    data_t       data;
    strb_t       strb;
    data_t       exp_data;
    logic        exp_err;
    string       name;
    data_t       rdata;
    logic        err;
    data_t       hw_access;
    data_t       hw_ready;
    data_t       hw_after;
    idx_t        idx;
    logic        ok;
    base     = n * WORDS_PER_OP;
    op       = vec_mem[base];
    addr     = vec_mem[base+1][ADDR_WIDTH-1:0];
    data     = vec_mem[base+2];
    strb     = vec_mem[base+3][STRB_WIDTH-1:0];
    exp_data = vec_mem[base+4];
    exp_err  = vec_mem[base+5][0];
    idx      = idx_t'(addr);  // register index for hw ops
    stop     = 1'b0;
    case (op)
      OP_WRITE: begin
        name = $sformatf("op %0d write %h", n, addr);
        apb_transfer(name, 1'b1, addr, data, strb, '0, rdata, err, hw_access, hw_ready, ok);
        if (ok) begin
          check_err({name, " pslverr"}, exp_err, err);
        end
      end
      OP_READ: begin
        name = $sformatf("op %0d read %h", n, addr);
        apb_transfer(name, 1'b0, addr, '0, '0, '0, rdata, err, hw_access, hw_ready, ok);
        if (ok) begin
          check_data({name, " prdata"}, exp_data, rdata);
          check_err({name, " pslverr"}, exp_err, err);
        end
      end
      OP_HW_DRIVE: begin
        @(posedge clk);
        #1;
        hw_in[idx] = data;  // held until the next drive
      end
      OP_TRIGGER: begin
        name = $sformatf("op %0d trigger %h", n, addr);
        idx  = idx_t'((addr - BASE_ADDRESS) >> 2);
        apb_transfer(name, 1'b1, addr, data, strb, idx, rdata, err, hw_access, hw_ready, ok);
        if (ok) begin
          hw_after = hw_out[idx];  // cycle right after the pulse
          check_data({name, " before write edge"}, '0, hw_access);
          check_data({name, " pulse"}, exp_data, hw_ready);
          check_data({name, " after pulse"}, '0, hw_after);
          check_err({name, " pslverr"}, exp_err, err);
        end
      end
      OP_HW_CHECK: begin
        name = $sformatf("op %0d hw_out[%0d]", n, idx);
        @(posedge clk);
        #1;
        check_data(name, exp_data, hw_out[idx]);
      end
      OP_END: begin
        stop = 1'b1;
      end
      default: begin
        $display("op %0d: unknown operation code %h in the vector file", n, op);
        fail_count++;
        stop = 1'b1;
      end
    endcase
  endtask

  // **********************************************************************
  // main sequence
  // **********************************************************************

  initial begin
    int   n;
    logic done;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pstrb       = '0;
    hw_in       = '0;
    pass_count  = 0;
    fail_count  = 0;
    timeout_hit = 1'b0;
    for (int i = 0; i < MAX_OPS*WORDS_PER_OP; i++) begin
      vec_mem[i] = {16'hBAD0, i[15:0]};  // unknown op if a line is missing
    end
    $readmemh("regblk_input.txt", vec_mem);

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_err("reset pready", 1'b0, pready);
    check_err("reset pslverr", 1'b0, pslverr);
    check_data("reset prdata", '0, prdata);

    n    = 0;
    done = 1'b0;
    while (!done && !timeout_hit && n < MAX_OPS) begin
      run_op(n, done);
      n++;
    end
    if (!done && !timeout_hit) begin
      $display("vector file has no end marker within %0d operations", MAX_OPS);
      fail_count++;
    end

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && !timeout_hit) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
